/* Bender.yml */
package:
  name: alut

sources:
  - src/alut_pkg.sv
  - src/alut_reg_bank.sv
  - src/alut_timer.sv
  - src/alut_addr_checker.sv
  - src/alut_age_checker.sv
  - src/alut_top.sv
  - target: test
    files:
      - tests/alut_sva.sv
      - tests/alut_tb.sv

/* sources.f */
src/alut_pkg.sv
src/alut_reg_bank.sv
src/alut_timer.sv
src/alut_addr_checker.sv
src/alut_age_checker.sv
src/alut_top.sv
tests/alut_sva.sv
tests/alut_tb.sv

/* src/alut_addr_checker.sv */
// address table owner; learns source addresses, looks up destination ports, serves the age scan
`timescale 1ns/1ns
`default_nettype none

module alut_addr_checker
   import alut_pkg::*;
(
   input  logic                   pclk19,
   input  logic                   n_p_reset19,
   input  alut_cmd_e              command,
   input  alut_frame_t            frame,
   input  logic [47:0]            mac_addr,
   input  logic [31:0]            curr_time,
   input  logic                   clear_reused,
   input  logic [TABLE_IDX_W-1:0] age_idx,
   input  logic                   age_inval,
   output logic                   add_check_active,
   output logic [4:0]             d_port,
   output logic                   reused,
   output alut_inval_t            lst_inv_nrm,
   output alut_entry_t            age_entry
);

   // table storage, only valid bits are reset
   logic [TABLE_DEPTH-1:0]  valid_q;
   logic [47:0]             mac_q   [TABLE_DEPTH];
   logic [1:0]              port_q  [TABLE_DEPTH];
   logic [31:0]             stamp_q [TABLE_DEPTH];

   logic [TABLE_IDX_W-1:0]  repl_ptr_q;            // round robin victim
   logic [1:0]              stage_q;               // 01 compare, 10 learn
   logic [TABLE_DEPTH-1:0]  d_match, s_match;
   logic [TABLE_DEPTH-1:0]  d_match_q, s_match_q;  // compare results
   logic                    self_q;                // dest is own address
   logic                    start, learn, flush, reuse;
   logic [TABLE_IDX_W-1:0]  learn_idx, d_idx;
   logic [4:0]              d_port_nxt;
   alut_entry_t             new_entry;

   // lowest set bit of a table wide vector
   function automatic logic [TABLE_IDX_W-1:0] first_set(input logic [TABLE_DEPTH-1:0] vec);
      logic [TABLE_IDX_W-1:0] idx;
      idx = '0;
      for (int i = TABLE_DEPTH - 1; i >= 0; i--)
         if (vec[i])
            idx = TABLE_IDX_W'(i);
      return idx;
   endfunction

   assign start            = (command == CMD_CHECK) && (stage_q == 2'b00);
   assign flush            = (command == CMD_FLUSH) && (stage_q == 2'b00);
   assign learn            = stage_q[1];
   assign add_check_active = |stage_q;

   // --------------------
   // parallel compare, first cycle
   always_comb
   begin
      for (int i = 0; i < TABLE_DEPTH; i++)
      begin
         d_match[i] = valid_q[i] && (mac_q[i] == frame.d_addr);
         s_match[i] = valid_q[i] && (mac_q[i] == frame.s_addr);
      end
   end

   always_ff @(posedge pclk19)
   begin
      if (stage_q[0])
      begin
         d_match_q <= d_match;
         s_match_q <= s_match;
         self_q    <= (frame.d_addr == mac_addr);
      end
   end

   // --------------------
   // second cycle, pick slot and dest
   always_comb
   begin
      reuse = 1'b0;
      if (|s_match_q)
         learn_idx = first_set(s_match_q);   // refresh known source
      else if (~&valid_q)
         learn_idx = first_set(~valid_q);    // lowest free slot
      else
      begin
         learn_idx = repl_ptr_q;             // full, evict
         reuse     = learn;
      end
      d_idx = first_set(d_match_q);
      if (self_q)
         d_port_nxt = D_PORT_SELF;
      else if (|d_match_q)
         d_port_nxt = 5'b00001 << port_q[d_idx];
      else
         d_port_nxt = {1'b0, ~(4'b0001 << frame.s_port)};   // flood, not back to source
   end

   always_comb
   begin
      new_entry.valid = 1'b1;
      new_entry.mac   = frame.s_addr;
      new_entry.port  = frame.s_port;
      new_entry.stamp = curr_time;
   end

   // --------------------
   // control state
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
      begin
         stage_q    <= '0;
         repl_ptr_q <= '0;
         reused     <= 1'b0;
         d_port     <= '0;
      end
      else
      begin
         stage_q <= {stage_q[0], start};
         if (learn)
            d_port <= d_port_nxt;
         if (reuse)
         begin
            repl_ptr_q <= repl_ptr_q + 1'b1;
            reused     <= 1'b1;   // wins over a clear
         end
         else if (clear_reused)
            reused <= 1'b0;
      end
   end

   // evicted entry, kept for the reg bank
   always_ff @(posedge pclk19)
   begin
      if (reuse)
      begin
         lst_inv_nrm.addr <= mac_q[learn_idx];
         lst_inv_nrm.port <= port_q[learn_idx];
      end
   end

   // valid bits, learn write beats age invalidate
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         valid_q <= '0;
      else
      begin
         if (flush)
            valid_q <= '0;
         if (age_inval)
            valid_q[age_idx] <= 1'b0;
         if (learn)
            valid_q[learn_idx] <= new_entry.valid;
      end
   end

   always_ff @(posedge pclk19)
   begin
      if (learn)
      begin
         mac_q[learn_idx]   <= new_entry.mac;
         port_q[learn_idx]  <= new_entry.port;
         stamp_q[learn_idx] <= new_entry.stamp;
      end
   end

   // read port for the age scan
   always_comb
   begin
      age_entry.valid = valid_q[age_idx];
      age_entry.mac   = mac_q[age_idx];
      age_entry.port  = port_q[age_idx];
      age_entry.stamp = stamp_q[age_idx];
   end

endmodule

`default_nettype wire

/* src/alut_age_checker.sv */
// age scan of the address table; on command drops every entry older than the best-before age
`timescale 1ns/1ns
`default_nettype none

module alut_age_checker
   import alut_pkg::*;
(
   input  logic                   pclk19,
   input  logic                   n_p_reset19,
   input  alut_cmd_e              command,
   input  logic [31:0]            curr_time,
   input  logic [31:0]            best_bfr_age,
   input  alut_entry_t            age_entry,
   output logic                   age_check_active,
   output logic [TABLE_IDX_W-1:0] age_idx,
   output logic                   age_inval,
   output logic                   inval_in_prog,
   output alut_inval_t            lst_inv_cmd
);

   logic [31:0] age;    // modular, survives time wrap
   logic        last;   // final slot of the scan

   assign last = (age_idx == TABLE_IDX_W'(TABLE_DEPTH - 1));
   assign age  = curr_time - age_entry.stamp;

   // --------------------
   // scan counter, one entry per cycle
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
      begin
         age_check_active <= 1'b0;
         age_idx          <= '0;
      end
      else if (!age_check_active)
      begin
         if (command == CMD_AGE)   // ignored while busy
         begin
            age_check_active <= 1'b1;
            age_idx          <= '0;
         end
      end
      else
      begin
         age_idx <= age_idx + 1'b1;
         if (last)
            age_check_active <= 1'b0;
      end
   end

   // --------------------
   // age rule, strictly older than limit
   assign age_inval     = age_check_active && age_entry.valid && (age > best_bfr_age);
   assign inval_in_prog = age_inval;   // status bit 1

   // record for the last invalidated regs
   always_comb
   begin
      lst_inv_cmd.addr = age_entry.mac;
      lst_inv_cmd.port = age_entry.port;
   end

endmodule

`default_nettype wire

/* src/alut_pkg.sv */
// shared offsets, sizes, command codes and bus/table structs for the address lookup unit
`default_nettype none

package alut_pkg;

   // --------------------
   // APB register map, word offsets
   localparam logic [6:0] AL_FRM_D_ADDR_L   = 7'd0;   // dest addr bits 31:0
   localparam logic [6:0] AL_FRM_D_ADDR_U   = 7'd1;   // dest addr bits 47:32
   localparam logic [6:0] AL_FRM_S_ADDR_L   = 7'd2;
   localparam logic [6:0] AL_FRM_S_ADDR_U   = 7'd3;
   localparam logic [6:0] AL_S_PORT         = 7'd4;   // source port of frame
   localparam logic [6:0] AL_D_PORT         = 7'd5;   // read only
   localparam logic [6:0] AL_MAC_ADDR_L     = 7'd6;   // own switch address
   localparam logic [6:0] AL_MAC_ADDR_U     = 7'd7;
   localparam logic [6:0] AL_CUR_TIME       = 7'd8;   // read only
   localparam logic [6:0] AL_BB_AGE         = 7'd9;
   localparam logic [6:0] AL_DIV_CLK        = 7'd10;
   localparam logic [6:0] AL_COMMAND        = 7'd11;  // self clearing
   localparam logic [6:0] AL_STATUS         = 7'd12;
   localparam logic [6:0] AL_LST_INV_ADDR_L = 7'd13;
   localparam logic [6:0] AL_LST_INV_ADDR_U = 7'd14;
   localparam logic [6:0] AL_LST_INV_PORT   = 7'd15;

   // --------------------
   // table geometry
   localparam int TABLE_DEPTH = 8;
   localparam int TABLE_IDX_W = 3;

   // frame is for the switch itself
   localparam logic [4:0] D_PORT_SELF = 5'b10000;

   // one cycle command codes
   typedef enum logic [1:0] {
      CMD_NONE  = 2'd0,
      CMD_CHECK = 2'd1,   // learn source, look up dest
      CMD_AGE   = 2'd2,   // scan and drop old entries
      CMD_FLUSH = 2'd3    // drop everything at once
   } alut_cmd_e;

   // --------------------
   // APB request, master to slave
   typedef struct packed {
      logic        sel;
      logic        enable;
      logic        write;
      logic [6:0]  addr;
      logic [31:0] wdata;
   } alut_apb_t;

   // frame under check
   typedef struct packed {
      logic [47:0] d_addr;
      logic [47:0] s_addr;
      logic [1:0]  s_port;
   } alut_frame_t;

   // one address table entry
   typedef struct packed {
      logic        valid;
      logic [47:0] mac;
      logic [1:0]  port;
      logic [31:0] stamp;   // time of learning
   } alut_entry_t;

   // record of a dropped entry
   typedef struct packed {
      logic [47:0] addr;
      logic [1:0]  port;
   } alut_inval_t;

endpackage

`default_nettype wire

/* src/alut_reg_bank.sv */
// APB register bank of the lookup unit; holds config, issues command pulses, reports status
`timescale 1ns/1ns
`default_nettype none

module alut_reg_bank
   import alut_pkg::*;
(
   input  logic        pclk19,
   input  logic        n_p_reset19,
   input  alut_apb_t   apb,
   input  logic [31:0] curr_time,
   input  logic        add_check_active,
   input  logic        age_check_active,
   input  logic        inval_in_prog,
   input  logic        reused,
   input  logic [4:0]  d_port,
   input  alut_inval_t lst_inv_nrm,
   input  alut_inval_t lst_inv_cmd,
   output logic [31:0] prdata,
   output alut_frame_t frame,
   output logic [47:0] mac_addr,
   output logic [31:0] best_bfr_age,
   output logic [7:0]  div_clk,
   output alut_cmd_e   command,
   output logic        clear_reused
);

   logic        read_en;     // setup phase of a read
   logic        write_en;    // enable phase of a write
   logic        active;      // either checker busy
   alut_inval_t lst_inv_q;   // last dropped addr and port

   assign read_en  = apb.sel & ~apb.enable & ~apb.write;
   assign write_en = apb.sel & apb.enable & apb.write;
   assign active   = add_check_active | age_check_active;

   // status read while idle acknowledges the reused flag
   assign clear_reused = read_en & (apb.addr == AL_STATUS) & ~active;

   // --------------------
   // writable config registers
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
      begin
         frame        <= '0;
         mac_addr     <= '0;
         best_bfr_age <= '1;     // nothing ages out by default
         div_clk      <= '0;
      end
      else if (write_en)
      begin
         case (apb.addr)
            AL_FRM_D_ADDR_L : frame.d_addr[31:0]  <= apb.wdata;
            AL_FRM_D_ADDR_U : frame.d_addr[47:32] <= apb.wdata[15:0];
            AL_FRM_S_ADDR_L : frame.s_addr[31:0]  <= apb.wdata;
            AL_FRM_S_ADDR_U : frame.s_addr[47:32] <= apb.wdata[15:0];
            AL_S_PORT       : frame.s_port        <= apb.wdata[1:0];
            AL_MAC_ADDR_L   : mac_addr[31:0]      <= apb.wdata;
            AL_MAC_ADDR_U   : mac_addr[47:32]     <= apb.wdata[15:0];
            AL_BB_AGE       : best_bfr_age        <= apb.wdata;
            AL_DIV_CLK      : div_clk             <= apb.wdata[7:0];
            default         : ;                   // read only or unmapped
         endcase
      end
   end

   // command lives one cycle, then clears
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         command <= CMD_NONE;
      else if (command != CMD_NONE)
         command <= CMD_NONE;   // writes in the pulse cycle are lost
      else if (write_en && (apb.addr == AL_COMMAND))
         command <= alut_cmd_e'(apb.wdata[1:0]);
   end

   // --------------------
   // last invalidated capture
   // replacement by the address checker beats ageing
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         lst_inv_q <= '0;
      else if (reused)
         lst_inv_q <= lst_inv_nrm;
      else if (inval_in_prog)
         lst_inv_q <= lst_inv_cmd;
   end

   // --------------------
   // read mux, data out in enable phase
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         prdata <= '0;
      else if (read_en)
      begin
         case (apb.addr)
            AL_FRM_D_ADDR_L   : prdata <= frame.d_addr[31:0];
            AL_FRM_D_ADDR_U   : prdata <= {16'd0, frame.d_addr[47:32]};
            AL_FRM_S_ADDR_L   : prdata <= frame.s_addr[31:0];
            AL_FRM_S_ADDR_U   : prdata <= {16'd0, frame.s_addr[47:32]};
            AL_S_PORT         : prdata <= {30'd0, frame.s_port};
            AL_D_PORT         : prdata <= {27'd0, d_port};
            AL_MAC_ADDR_L     : prdata <= mac_addr[31:0];
            AL_MAC_ADDR_U     : prdata <= {16'd0, mac_addr[47:32]};
            AL_CUR_TIME       : prdata <= curr_time;
            AL_BB_AGE         : prdata <= best_bfr_age;
            AL_DIV_CLK        : prdata <= {24'd0, div_clk};
            AL_STATUS         : prdata <= {29'd0, reused, inval_in_prog, active};
            AL_LST_INV_ADDR_L : prdata <= lst_inv_q.addr[31:0];
            AL_LST_INV_ADDR_U : prdata <= {16'd0, lst_inv_q.addr[47:32]};
            AL_LST_INV_PORT   : prdata <= {30'd0, lst_inv_q.port};
            default           : prdata <= '0;   // AL_COMMAND and holes
         endcase
      end
      else
         prdata <= '0;   // bus quiet outside read
   end

endmodule

`default_nettype wire

/* src/alut_timer.sv */
// time base of the lookup unit; prescales pclk19 and counts the current time used for ageing
`timescale 1ns/1ns
`default_nettype none

module alut_timer
(
   input  logic        pclk19,
   input  logic        n_p_reset19,
   input  logic [7:0]  div_clk,
   output logic [31:0] curr_time
);

   logic [7:0] presc_q;   // prescale count
   logic [7:0] div_q;     // divider in use this period
   logic       wrap;

   assign wrap = (presc_q == div_q);

   // --------------------
   // a new divider is only picked up on wrap
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
      begin
         presc_q   <= '0;
         div_q     <= '0;
         curr_time <= '0;
      end
      else if (wrap)
      begin
         presc_q   <= '0;
         div_q     <= div_clk;
         curr_time <= curr_time + 32'd1;   // one tick per div+1 clocks
      end
      else
         presc_q <= presc_q + 8'd1;
   end

endmodule

`default_nettype wire

/* src/alut_top.sv */
// top of the address lookup unit; ties the APB register bank to the timer and table checkers
`timescale 1ns/1ns
`default_nettype none

module alut_top
   import alut_pkg::*;
(
   input  logic        pclk19,
   input  logic        n_p_reset19,
   input  alut_apb_t   apb,
   output logic [31:0] prdata
);

   // --------------------
   // internal wires
   alut_frame_t            frame;
   logic [47:0]            mac_addr;
   logic [31:0]            best_bfr_age;
   logic [7:0]             div_clk;
   alut_cmd_e              command;
   logic                   clear_reused;
   logic [31:0]            curr_time;
   logic                   add_check_active, age_check_active;
   logic                   inval_in_prog, reused;
   logic [4:0]             d_port;
   alut_inval_t            lst_inv_nrm, lst_inv_cmd;
   logic [TABLE_IDX_W-1:0] age_idx;          // scan read index
   logic                   age_inval;
   alut_entry_t            age_entry;

   alut_reg_bank u_reg_bank (
      .pclk19           (pclk19),
      .n_p_reset19      (n_p_reset19),
      .apb              (apb),
      .curr_time        (curr_time),
      .add_check_active (add_check_active),
      .age_check_active (age_check_active),
      .inval_in_prog    (inval_in_prog),
      .reused           (reused),
      .d_port           (d_port),
      .lst_inv_nrm      (lst_inv_nrm),
      .lst_inv_cmd      (lst_inv_cmd),
      .prdata           (prdata),
      .frame            (frame),
      .mac_addr         (mac_addr),
      .best_bfr_age     (best_bfr_age),
      .div_clk          (div_clk),
      .command          (command),
      .clear_reused     (clear_reused)
   );

   alut_timer u_timer (
      .pclk19      (pclk19),
      .n_p_reset19 (n_p_reset19),
      .div_clk     (div_clk),
      .curr_time   (curr_time)
   );

   alut_addr_checker u_addr_checker (
      .pclk19           (pclk19),
      .n_p_reset19      (n_p_reset19),
      .command          (command),
      .frame            (frame),
      .mac_addr         (mac_addr),
      .curr_time        (curr_time),
      .clear_reused     (clear_reused),
      .age_idx          (age_idx),
      .age_inval        (age_inval),
      .add_check_active (add_check_active),
      .d_port           (d_port),
      .reused           (reused),
      .lst_inv_nrm      (lst_inv_nrm),
      .age_entry        (age_entry)
   );

   alut_age_checker u_age_checker (
      .pclk19           (pclk19),
      .n_p_reset19      (n_p_reset19),
      .command          (command),
      .curr_time        (curr_time),
      .best_bfr_age     (best_bfr_age),
      .age_entry        (age_entry),
      .age_check_active (age_check_active),
      .age_idx          (age_idx),
      .age_inval        (age_inval),
      .inval_in_prog    (inval_in_prog),
      .lst_inv_cmd      (lst_inv_cmd)
   );

endmodule

`default_nettype wire

/* tests/alut_sva.sv */
// concurrent checks on command pulses and APB phases that bind into every alut_reg_bank instance
`timescale 1ns/1ns
`default_nettype none

module alut_sva
   import alut_pkg::*;
(
   input logic       pclk19,
   input logic       n_p_reset19,
   input alut_apb_t  apb,
   input logic       read_en,
   input logic       write_en,
   input alut_cmd_e  command,
   input logic [7:0] div_clk,
   input logic       add_check_active,
   input logic       age_check_active
);

   logic wr_en;   // write enable decoded from the bus itself

   assign wr_en = apb.sel & apb.enable & apb.write;

   // --------------------
   // command is a one cycle pulse
   cmd_pulse_a : assert property (@(posedge pclk19) disable iff (!n_p_reset19)
      (command != CMD_NONE) |=> (command == CMD_NONE))
      else $error("command register held a code for two cycles");

   // register bank decode of the two phases
   rd_wr_excl_a : assert property (@(posedge pclk19) disable iff (!n_p_reset19)
      !(read_en && write_en))
      else $error("read and write enable high together");

   // only one checker busy at a time
   busy_excl_a : assert property (@(posedge pclk19) disable iff (!n_p_reset19)
      !(add_check_active && age_check_active))
      else $error("address and age checker active together");

   div_wr_a : assert property (@(posedge pclk19) disable iff (!n_p_reset19)
      (wr_en && (apb.addr == AL_DIV_CLK)) |=> (div_clk == $past(apb.wdata[7:0])))
      else $error("divider register did not take the written byte");

endmodule

bind alut_reg_bank alut_sva u_sva (
   .pclk19           (pclk19),
   .n_p_reset19      (n_p_reset19),
   .apb              (apb),
   .read_en          (read_en),
   .write_en         (write_en),
   .command          (command),
   .div_clk          (div_clk),
   .add_check_active (add_check_active),
   .age_check_active (age_check_active)
);

`default_nettype wire

/* tests/alut_tb.sv */
// testbench for alut_top that drives APB, mirrors the address table in a model and checks results
`timescale 1ns/1ns
`default_nettype none

module alut_tb
   import alut_pkg::*;
();

   localparam int          MAX_CYCLES = 40000;   // about 3x the full run
   localparam int          POLL_LIMIT = 20;
   localparam logic [47:0] OWN_MAC    = 48'h0a0b_0c0d_0e0f;

   logic        pclk19;
   logic        n_p_reset19;
   alut_apb_t   apb;
   logic [31:0] prdata;

   int          seed = 32'hd2f9;
   int          cycles = 0;
   logic [47:0] pool [12];   // small address pool so lookups hit

   // --------------------
   // reference model state
   logic        m_valid [TABLE_DEPTH];
   logic [47:0] m_mac   [TABLE_DEPTH];
   logic [1:0]  m_port  [TABLE_DEPTH];
   int          m_ptr;          // round robin victim
   logic        m_reused;
   logic [47:0] m_inv_addr;     // last dropped entry
   logic [1:0]  m_inv_port;

   // writable registers and their widths
   logic [6:0]  wr_addr [9] = '{AL_FRM_D_ADDR_L, AL_FRM_D_ADDR_U, AL_FRM_S_ADDR_L,
                                AL_FRM_S_ADDR_U, AL_S_PORT, AL_MAC_ADDR_L,
                                AL_MAC_ADDR_U, AL_BB_AGE, AL_DIV_CLK};
   logic [31:0] wr_mask [9] = '{32'hffff_ffff, 32'h0000_ffff, 32'hffff_ffff,
                                32'h0000_ffff, 32'h0000_0003, 32'hffff_ffff,
                                32'h0000_ffff, 32'hffff_ffff, 32'h0000_00ff};

   alut_top DUT (
      .pclk19      (pclk19),
      .n_p_reset19 (n_p_reset19),
      .apb         (apb),
      .prdata      (prdata)
   );

   initial
   begin
      pclk19 = 1'b0;
      forever #2 pclk19 = ~pclk19;
   end

   // run length guard
   always @(posedge pclk19)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("run stopped, cycle limit reached before the tests finished");
         $display("Test failed");
         $fatal(1);
      end
   end

   // --------------------
   // compare helpers
   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         $display("error: %s expected %h actual %h", name, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic check_port(input string name, input logic [4:0] exp, input logic [4:0] act);
      if (act !== exp)
      begin
         $display("error: %s expected %b actual %b", name, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // --------------------
   // APB master
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
      @(posedge pclk19);
      apb <= '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};
      @(posedge pclk19);
      apb.enable <= 1'b1;   // write lands at the next edge
      @(posedge pclk19);
      apb <= '0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      @(posedge pclk19);
      apb <= '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: 32'd0};
      @(posedge pclk19);
      apb.enable <= 1'b1;
      @(negedge pclk19);
      data = prdata;        // registered data is steady mid enable phase
      @(posedge pclk19);
      apb <= '0;
   endtask

   // polls status bit 0 and returns the idle status word
   task automatic wait_idle(output logic [31:0] status);
      int polls;
      polls = 0;
      apb_read(AL_STATUS, status);
      while (status[0])
      begin
         polls++;
         if (polls > POLL_LIMIT)
         begin
            $display("status busy bit did not drop within %0d polls", POLL_LIMIT);
            $display("Test failed");
            $fatal(1);
         end
         apb_read(AL_STATUS, status);
      end
   endtask

   // --------------------
   // model of the table rules
   function automatic logic [4:0] model_dport(input logic [47:0] d, input logic [1:0] s_port);
      logic [4:0] res;
      int         hit;
      hit = -1;
      for (int i = TABLE_DEPTH - 1; i >= 0; i--)
         if (m_valid[i] && (m_mac[i] == d))
            hit = i;
      res = 5'd0;
      if (d == OWN_MAC)
         res[4] = 1'b1;           // to the switch itself
      else if (hit >= 0)
         res[m_port[hit]] = 1'b1;
      else
      begin
         res = 5'b01111;          // flood all ports
         res[s_port] = 1'b0;      // but not the source
      end
      return res;
   endfunction

   task automatic model_learn(input logic [47:0] s, input logic [1:0] port);
      int slot;
      slot = -1;
      for (int i = TABLE_DEPTH - 1; i >= 0; i--)
         if (m_valid[i] && (m_mac[i] == s))
            slot = i;
      if (slot < 0)
         for (int i = TABLE_DEPTH - 1; i >= 0; i--)
            if (!m_valid[i])
               slot = i;          // lowest free
      if (slot < 0)
      begin
         slot       = m_ptr;      // table full so the victim goes
         m_inv_addr = m_mac[slot];
         m_inv_port = m_port[slot];
         m_reused   = 1'b1;
         m_ptr      = (m_ptr + 1) % TABLE_DEPTH;
      end
      m_valid[slot] = 1'b1;
      m_mac[slot]   = s;
      m_port[slot]  = port;
   endtask

   // --------------------
   // command sequences
   task automatic run_check(input string name, input logic [47:0] d, input logic [47:0] s,
                            input logic [1:0] port);
      logic [4:0]  exp_port;
      logic [31:0] rd;
      apb_write(AL_FRM_D_ADDR_L, d[31:0]);
      apb_write(AL_FRM_D_ADDR_U, {16'd0, d[47:32]});
      apb_write(AL_FRM_S_ADDR_L, s[31:0]);
      apb_write(AL_FRM_S_ADDR_U, {16'd0, s[47:32]});
      apb_write(AL_S_PORT, {30'd0, port});
      exp_port = model_dport(d, port);   // lookup sees the table before learning
      model_learn(s, port);
      apb_write(AL_COMMAND, {30'd0, CMD_CHECK});
      wait_idle(rd);
      check_word({name, " status"}, {29'd0, m_reused, 2'b00}, rd);
      m_reused = 1'b0;                    // idle status read acks it
      check_port({name, " d_port"}, exp_port, DUT.u_addr_checker.d_port);
      apb_read(AL_D_PORT, rd);
      check_word({name, " d_port reg"}, {27'd0, exp_port}, rd);
   endtask

   task automatic run_cmd(input string name, input alut_cmd_e cmd);
      logic [31:0] rd;
      apb_write(AL_COMMAND, {30'd0, cmd});
      wait_idle(rd);
      check_word({name, " status"}, 32'd0, rd);
   endtask

   task automatic check_lst_inv(input string name);
      logic [31:0] rd;
      apb_read(AL_LST_INV_ADDR_L, rd);
      check_word({name, " inv addr lo"}, m_inv_addr[31:0], rd);
      apb_read(AL_LST_INV_ADDR_U, rd);
      check_word({name, " inv addr hi"}, {16'd0, m_inv_addr[47:32]}, rd);
      apb_read(AL_LST_INV_PORT, rd);
      check_word({name, " inv port"}, {30'd0, m_inv_port}, rd);
   endtask

   // --------------------
   // main sequence
   initial
   begin
      logic [31:0] rd;
      logic [31:0] wd;
      logic [31:0] t_prev;
      int          r;
      n_p_reset19 = 1'b0;
      apb         = '0;
      m_ptr       = 0;
      m_reused    = 1'b0;
      m_inv_addr  = '0;
      m_inv_port  = '0;
      for (int i = 0; i < TABLE_DEPTH; i++)
         m_valid[i] = 1'b0;
      for (int i = 0; i < 12; i++)
         pool[i] = {16'h0200 + 16'(i), $random(seed)};   // upper half keeps them distinct
      repeat (10) @(posedge pclk19);
      n_p_reset19 <= 1'b1;

      // reset values of all but the time register
      for (int a = 0; a < 16; a++)
         if (a != AL_CUR_TIME)
         begin
            apb_read(7'(a), rd);
            check_word("reset value", (a == AL_BB_AGE) ? 32'hffff_ffff : 32'd0, rd);
         end
      repeat (8)
      begin
         apb_read(7'(16 + rand_below(112)), rd);
         check_word("unmapped read", 32'd0, rd);
      end

      // register round trip
      for (int k = 0; k < 9; k++)
      begin
         wd = $random(seed);
         apb_write(wr_addr[k], wd);
         apb_read(wr_addr[k], rd);
         check_word("round trip", wd & wr_mask[k], rd);
      end
      apb_read(AL_COMMAND, rd);
      check_word("command read", 32'd0, rd);
      apb_write(AL_MAC_ADDR_L, OWN_MAC[31:0]);
      apb_write(AL_MAC_ADDR_U, {16'd0, OWN_MAC[47:32]});
      apb_write(AL_BB_AGE, 32'hffff_ffff);
      apb_write(AL_DIV_CLK, 32'd0);       // one time tick per clock

      // random check frame traffic
      repeat (300)
      begin
         r = rand_below(13);
         run_check("check_rand", (r == 12) ? OWN_MAC : pool[r], pool[rand_below(12)],
                   2'(rand_below(4)));
      end

      // overflow from an empty table
      run_cmd("flush", CMD_FLUSH);
      for (int i = 0; i < TABLE_DEPTH; i++)
         m_valid[i] = 1'b0;
      for (int k = 0; k < 9; k++)
         run_check("overflow", pool[11], pool[k], 2'(rand_below(4)));
      check_lst_inv("overflow");
      apb_read(AL_STATUS, rd);
      check_word("reused cleared", 32'd0, rd);

      // ageing where nothing is old enough yet
      run_cmd("age_keep", CMD_AGE);
      check_lst_inv("age_keep");
      for (int i = 0; i < TABLE_DEPTH; i++)
         if (m_valid[i] && (i % 2 == 0))
            run_check("age_keep_hit", m_mac[i], pool[rand_below(12)], 2'(rand_below(4)));

      // then everything is older than zero
      apb_write(AL_BB_AGE, 32'd0);
      run_cmd("age_drop", CMD_AGE);
      for (int i = 0; i < TABLE_DEPTH; i++)
         if (m_valid[i])
         begin
            m_inv_addr = m_mac[i];        // scan order leaves the highest valid index last
            m_inv_port = m_port[i];
            m_valid[i] = 1'b0;
         end
      check_lst_inv("age_drop");
      apb_write(AL_BB_AGE, 32'hffff_ffff);
      for (int k = 0; k < 4; k++)
         run_check("age_drop_miss", pool[k], pool[k + 4], 2'(rand_below(4)));

      // flush followed by lookups of unknown destinations
      run_cmd("flush", CMD_FLUSH);
      for (int i = 0; i < TABLE_DEPTH; i++)
         m_valid[i] = 1'b0;
      for (int k = 1; k < 9; k++)
         run_check("flush_miss", pool[k], pool[0], 2'd1);

      // time never runs backwards
      t_prev = '0;
      repeat (30)
      begin
         apb_write(AL_DIV_CLK, 32'(rand_below(4)));
         apb_read(AL_CUR_TIME, rd);
         if (rd < t_prev)
         begin
            $display("current time went backwards from %0d to %0d", t_prev, rd);
            $display("Test failed");
            $fatal(1);
         end
         t_prev = rd;
      end

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire
